//--- tank_pkg.sv
// screen timing, grid geometry, tank shape, colours, direction and command enums
package tank_pkg;

  // 640x480 raster, counts in pixels
  localparam int H_ACTIVE     = 640;
  localparam int H_SYNC_START = 656; // hsync low from here
  localparam int H_SYNC_END   = 752; // back high here
  localparam int H_TOTAL      = 800;
  localparam int V_ACTIVE     = 480;
  localparam int V_SYNC_START = 490; // vsync low on lines 490..491
  localparam int V_SYNC_END   = 492;
  localparam int V_TOTAL      = 525;

  // grid, cell centres at origin + cell * size
  localparam int CELL_SIZE = 20;
  localparam int ORIGIN_X  = 160;
  localparam int ORIGIN_Y  = 40;
  localparam int GRID_COLS = 16;
  localparam int GRID_ROWS = 20;

  // play field edges, half a cell around the outer centres
  localparam int FIELD_X_LO = ORIGIN_X - 10;
  localparam int FIELD_X_HI = ORIGIN_X + GRID_COLS * CELL_SIZE - 11;
  localparam int FIELD_Y_LO = ORIGIN_Y - 10;
  localparam int FIELD_Y_HI = ORIGIN_Y + GRID_ROWS * CELL_SIZE - 11;

  // tank outline, offsets from the centre
  localparam int BODY_HALF   = 6; // 13x13 body square
  localparam int BARREL_HALF = 1; // barrel 3 px wide
  localparam int BARREL_LEN  = 3; // offsets 7..9 on the facing side

  // 12-bit rgb
  localparam logic [11:0] COLOR_MINE  = 12'h00F; // player, blue
  localparam logic [11:0] COLOR_ENEMY = 12'hF00; // enemy, red
  localparam logic [11:0] COLOR_FIELD = 12'h222; // dark grey
  localparam logic [11:0] COLOR_BLACK = 12'h000;

  // up is toward smaller y
  typedef enum logic [1:0] {DIR_UP, DIR_DOWN, DIR_LEFT, DIR_RIGHT} tank_dir_e;

  typedef enum logic [2:0] {
    CMD_NOP, CMD_UP, CMD_DOWN, CMD_LEFT, CMD_RIGHT, CMD_SPAWN, CMD_KILL
  } tank_cmd_e;

endpackage

//--- vga_timing.sv
// raster counters, sync and active decode for 640x480
`timescale 1ns/1ps

module vga_timing
(
  input  logic       clk,
  input  logic       rst,
  output logic [9:0] px_x,      // current column
  output logic [9:0] px_y,      // current line
  output logic       active,    // px inside visible area
  output logic       hsync_raw, // active low, aligned with px
  output logic       vsync_raw
);

  logic [9:0] next_x;
  logic [9:0] next_y;

  // raster step, line wrap then frame wrap
  always_comb
  begin
    next_x = px_x + 10'd1;
    next_y = px_y;
    if (px_x == 10'(tank_pkg::H_TOTAL - 1))
    begin
      next_x = '0;
      if (px_y == 10'(tank_pkg::V_TOTAL - 1))
        next_y = '0;
      else
        next_y = px_y + 10'd1;
    end
  end

  // decode from the next position so flags line up with the counters
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      px_x      <= '0;
      px_y      <= '0;
      active    <= 1'b1; // pixel (0,0) is visible
      hsync_raw <= 1'b1;
      vsync_raw <= 1'b1;
    end
    else
    begin
      px_x      <= next_x;
      px_y      <= next_y;
      active    <= (next_x < tank_pkg::H_ACTIVE) && (next_y < tank_pkg::V_ACTIVE);
      hsync_raw <= !((next_x >= tank_pkg::H_SYNC_START) && (next_x < tank_pkg::H_SYNC_END));
      vsync_raw <= !((next_y >= tank_pkg::V_SYNC_START) && (next_y < tank_pkg::V_SYNC_END));
    end
  end

  // column never runs past the line length
  a_x_range: assert property (@(posedge clk) disable iff (rst)
    px_x < tank_pkg::H_TOTAL);

endmodule

//--- tank_ctrl.sv
// one tank's cell, facing and alive state with turn-then-move commands
`timescale 1ns/1ps

module tank_ctrl
#(
  parameter logic [4:0] SPAWN_X = 5'd7,
  parameter logic [4:0] SPAWN_Y = 5'd18
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cmd_valid, // one-cycle strobe
  input  tank_pkg::tank_cmd_e  cmd,
  output logic [4:0]           cell_x,
  output logic [4:0]           cell_y,
  output tank_pkg::tank_dir_e  dir,
  output logic                 alive
);

  tank_pkg::tank_dir_e want_dir; // facing asked for by the command
  logic [4:0]          step_x;   // cell after one step, clamped
  logic [4:0]          step_y;

  always_comb
  begin
    want_dir = dir;
    step_x   = cell_x;
    step_y   = cell_y;
    case (cmd)
      tank_pkg::CMD_UP:
      begin
        want_dir = tank_pkg::DIR_UP;
        if (cell_y != 5'd0)
          step_y = cell_y - 5'd1; // up is smaller y
      end
      tank_pkg::CMD_DOWN:
      begin
        want_dir = tank_pkg::DIR_DOWN;
        if (cell_y != 5'(tank_pkg::GRID_ROWS - 1))
          step_y = cell_y + 5'd1;
      end
      tank_pkg::CMD_LEFT:
      begin
        want_dir = tank_pkg::DIR_LEFT;
        if (cell_x != 5'd0)
          step_x = cell_x - 5'd1;
      end
      tank_pkg::CMD_RIGHT:
      begin
        want_dir = tank_pkg::DIR_RIGHT;
        if (cell_x != 5'(tank_pkg::GRID_COLS - 1))
          step_x = cell_x + 5'd1;
      end
      default:
      begin
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cell_x <= SPAWN_X;
      cell_y <= SPAWN_Y;
      dir    <= tank_pkg::DIR_UP;
      alive  <= 1'b1;
    end
    else if (cmd_valid)
    begin
      case (cmd)
        tank_pkg::CMD_UP, tank_pkg::CMD_DOWN, tank_pkg::CMD_LEFT, tank_pkg::CMD_RIGHT:
        begin
          if (alive && (dir == want_dir))
          begin
            cell_x <= step_x; // already facing, so move
            cell_y <= step_y;
          end
          else
            dir <= want_dir; // turn only
        end
        tank_pkg::CMD_SPAWN:
        begin
          cell_x <= SPAWN_X;
          cell_y <= SPAWN_Y;
          dir    <= tank_pkg::DIR_UP;
          alive  <= 1'b1;
        end
        tank_pkg::CMD_KILL: alive <= 1'b0;
        default:
        begin
        end
      endcase
    end
  end

  // clamping keeps the tank on the grid
  a_cell_range: assert property (@(posedge clk) disable iff (rst)
    (cell_x < tank_pkg::GRID_COLS) && (cell_y < tank_pkg::GRID_ROWS));

endmodule

//--- tank_render.sv
// per-pixel tank body and barrel test, registered colour and hit
`timescale 1ns/1ps

module tank_render
#(
  parameter logic [11:0] TANK_COLOR = tank_pkg::COLOR_MINE
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [9:0]           px_x,
  input  logic [9:0]           px_y,
  input  logic                 active,
  input  logic [4:0]           cell_x,
  input  logic [4:0]           cell_y,
  input  tank_pkg::tank_dir_e  dir,
  input  logic                 alive,
  output logic                 hit,   // one cycle after px
  output logic [11:0]          color
);

  logic [10:0]        cx;      // tank centre in pixels
  logic [10:0]        cy;
  logic signed [11:0] dx;      // pixel minus centre
  logic signed [11:0] dy;
  logic [11:0]        abs_x;
  logic [11:0]        abs_y;
  logic               body;
  logic               thin_x;  // within barrel half-width across x
  logic               thin_y;
  logic               tip_x;   // along-axis span of the barrel
  logic               tip_y;
  logic               barrel;
  logic               on_tank;

  assign cx = 11'(tank_pkg::ORIGIN_X) + 11'(cell_x) * 11'(tank_pkg::CELL_SIZE);
  assign cy = 11'(tank_pkg::ORIGIN_Y) + 11'(cell_y) * 11'(tank_pkg::CELL_SIZE);

  assign dx = $signed({2'b00, px_x}) - $signed({1'b0, cx});
  assign dy = $signed({2'b00, px_y}) - $signed({1'b0, cy});

  assign abs_x = dx[11] ? 12'(-dx) : 12'(dx);
  assign abs_y = dy[11] ? 12'(-dy) : 12'(dy);

  assign body   = (abs_x <= tank_pkg::BODY_HALF) && (abs_y <= tank_pkg::BODY_HALF);
  assign thin_x = abs_x <= tank_pkg::BARREL_HALF;
  assign thin_y = abs_y <= tank_pkg::BARREL_HALF;
  assign tip_x  = (abs_x > tank_pkg::BODY_HALF) &&
                  (abs_x <= tank_pkg::BODY_HALF + tank_pkg::BARREL_LEN);
  assign tip_y  = (abs_y > tank_pkg::BODY_HALF) &&
                  (abs_y <= tank_pkg::BODY_HALF + tank_pkg::BARREL_LEN);

  // barrel rotated by facing with the offset sign picking the side
  always_comb
  begin
    case (dir)
      tank_pkg::DIR_UP:    barrel = thin_x && tip_y && dy[11];
      tank_pkg::DIR_DOWN:  barrel = thin_x && tip_y && !dy[11];
      tank_pkg::DIR_LEFT:  barrel = thin_y && tip_x && dx[11];
      default:             barrel = thin_y && tip_x && !dx[11]; // right
    endcase
  end

  assign on_tank = alive && active && (body || barrel);

  always_ff @(posedge clk)
  begin
    if (rst)
      hit <= 1'b0;
    else
      hit <= on_tank;
  end

  always_ff @(posedge clk)
  begin
    color <= on_tank ? TANK_COLOR : tank_pkg::COLOR_BLACK;
  end

  // painted pixels come from a live tank and stay within barrel reach
  a_hit_alive: assert property (@(posedge clk) disable iff (rst)
    hit |-> $past(alive &&
                  (abs_x <= tank_pkg::BODY_HALF + tank_pkg::BARREL_LEN) &&
                  (abs_y <= tank_pkg::BODY_HALF + tank_pkg::BARREL_LEN)));

endmodule

//--- pixel_mixer.sv
// tank priority, field background and sync alignment to the render stage
`timescale 1ns/1ps

module pixel_mixer
(
  input  logic        clk,
  input  logic        rst,
  input  logic [9:0]  px_x,
  input  logic [9:0]  px_y,
  input  logic        active,
  input  logic        hsync_raw,
  input  logic        vsync_raw,
  input  logic        mine_hit,    // already one cycle behind px
  input  logic [11:0] mine_color,
  input  logic        enemy_hit,
  input  logic [11:0] enemy_color,
  output logic [11:0] rgb,
  output logic        hsync,
  output logic        vsync
);

  logic in_field;
  logic field_d;   // matches renderer latency
  logic hsync_d;
  logic vsync_d;

  assign in_field = active &&
                    (px_x >= tank_pkg::FIELD_X_LO) && (px_x <= tank_pkg::FIELD_X_HI) &&
                    (px_y >= tank_pkg::FIELD_Y_LO) && (px_y <= tank_pkg::FIELD_Y_HI);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      field_d <= 1'b0;
      hsync_d <= 1'b1;
      vsync_d <= 1'b1;
      rgb     <= tank_pkg::COLOR_BLACK;
      hsync   <= 1'b1; // syncs idle high
      vsync   <= 1'b1;
    end
    else
    begin
      field_d <= in_field;
      hsync_d <= hsync_raw;
      vsync_d <= vsync_raw;
      hsync   <= hsync_d; // two stages total
      vsync   <= vsync_d;
      if (mine_hit)
        rgb <= mine_color; // player wins overlap
      else if (enemy_hit)
        rgb <= enemy_color;
      else if (field_d)
        rgb <= tank_pkg::COLOR_FIELD;
      else
        rgb <= tank_pkg::COLOR_BLACK; // border and blanking
    end
  end

endmodule

//--- tank_display.sv
// top level, command steering and the display pipeline instances
`timescale 1ns/1ps

module tank_display
(
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_valid,
  input  logic                cmd_tank,  // 1 selects the player
  input  tank_pkg::tank_cmd_e cmd,
  output logic [11:0]         rgb,
  output logic                hsync,
  output logic                vsync
);

  logic [9:0]          px_x;
  logic [9:0]          px_y;
  logic                active;
  logic                hsync_raw;
  logic                vsync_raw;
  logic                mine_valid;
  logic                enemy_valid;
  logic [4:0]          mine_x;
  logic [4:0]          mine_y;
  tank_pkg::tank_dir_e mine_dir;
  logic                mine_alive;
  logic [4:0]          enemy_x;
  logic [4:0]          enemy_y;
  tank_pkg::tank_dir_e enemy_dir;
  logic                enemy_alive;
  logic                mine_hit;
  logic [11:0]         mine_color;
  logic                enemy_hit;
  logic [11:0]         enemy_color;

  // strobe goes only to the selected tank
  assign mine_valid  = cmd_valid && cmd_tank;
  assign enemy_valid = cmd_valid && !cmd_tank;

  vga_timing u_timing (.clk, .rst, .px_x, .px_y, .active, .hsync_raw, .vsync_raw);

  tank_ctrl #(.SPAWN_X(5'd7), .SPAWN_Y(5'd18)) u_mine_ctrl ( // bottom centre
    .clk, .rst, .cmd_valid(mine_valid), .cmd,
    .cell_x(mine_x), .cell_y(mine_y), .dir(mine_dir), .alive(mine_alive));

  tank_ctrl #(.SPAWN_X(5'd7), .SPAWN_Y(5'd1)) u_enemy_ctrl ( // near the top
    .clk, .rst, .cmd_valid(enemy_valid), .cmd,
    .cell_x(enemy_x), .cell_y(enemy_y), .dir(enemy_dir), .alive(enemy_alive));

  tank_render #(.TANK_COLOR(tank_pkg::COLOR_MINE)) u_mine_render (
    .clk, .rst, .px_x, .px_y, .active,
    .cell_x(mine_x), .cell_y(mine_y), .dir(mine_dir), .alive(mine_alive),
    .hit(mine_hit), .color(mine_color));

  tank_render #(.TANK_COLOR(tank_pkg::COLOR_ENEMY)) u_enemy_render (
    .clk, .rst, .px_x, .px_y, .active,
    .cell_x(enemy_x), .cell_y(enemy_y), .dir(enemy_dir), .alive(enemy_alive),
    .hit(enemy_hit), .color(enemy_color));

  pixel_mixer u_mixer (
    .clk, .rst, .px_x, .px_y, .active, .hsync_raw, .vsync_raw,
    .mine_hit, .mine_color, .enemy_hit, .enemy_color,
    .rgb, .hsync, .vsync);

endmodule

//--- tb_clock_gen.sv
// testbench clock and synchronous reset source
`timescale 1ns/1ps

module tb_clock_gen
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  // reset held for 16 rising edges, dropped on a falling edge
  initial
  begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

//--- tank_display_tb.sv
// testbench for tank_display, driven from the tank_cases.txt command and probe list
`timescale 1ns/1ps

module tank_display_tb;

  localparam int FRAME_CYCLES = tank_pkg::H_TOTAL * tank_pkg::V_TOTAL;
  localparam int PIPE_DELAY   = 2; // counters to rgb/sync outputs

  logic                clk;
  logic                rst;
  logic                cmd_valid;
  logic                cmd_tank;
  tank_pkg::tank_cmd_e cmd;
  logic [11:0]         rgb;
  logic                hsync;
  logic                vsync;

  int edge_count = 0; // rising edges since reset release
  int errors     = 0;
  int case_count = 0;

  tb_clock_gen u_clock (.clk, .rst);

  tank_display DUT (.clk, .rst, .cmd_valid, .cmd_tank, .cmd, .rgb, .hsync, .vsync);

  always @(posedge clk)
  begin
    if (rst)
      edge_count <= 0;
    else
      edge_count <= edge_count + 1;
  end

  task automatic wait_reset(output bit ok);
    ok = 1'b0;
    for (int i = 0; i < 64 && !ok; i++)
    begin
      @(negedge clk);
      ok = !rst;
    end
  endtask

  // one-cycle strobe, then a few idle cycles so later pixels see the new state
  task automatic send_cmd(input int tank, input int op);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd_tank  = (tank != 0);
    cmd       = tank_pkg::tank_cmd_e'(3'(op));
    @(negedge clk);
    cmd_valid = 1'b0;
    cmd       = tank_pkg::CMD_NOP;
    repeat (4) @(negedge clk);
    $display("case %0d: command to %s tank, op %0d", case_count,
             (tank != 0) ? "player" : "enemy", op);
  endtask

  // step falling edges until the outputs carry raster pixel (x,y)
  task automatic find_pixel(input int x, input int y, output bit found);
    int n;
    int px;
    int py;
    found = 1'b0;
    for (int i = 0; i < FRAME_CYCLES + 8 && !found; i++)
    begin
      @(negedge clk);
      n = edge_count - PIPE_DELAY;
      if (n >= 0)
      begin
        px = n % tank_pkg::H_TOTAL;
        py = (n / tank_pkg::H_TOTAL) % tank_pkg::V_TOTAL;
        found = (px == x) && (py == y);
      end
    end
  endtask

  task automatic probe(input int x, input int y, input int exp_rgb, input int exp_h,
                       input int exp_v);
    bit found;
    bit bad;
    bad = 1'b0;
    find_pixel(x, y, found);
    if (!found)
    begin
      $display("case %0d: timed out waiting for pixel (%0d,%0d)", case_count, x, y);
      errors++;
    end
    else
    begin
      if (rgb != 12'(exp_rgb))
      begin
        $display("[FAIL] case %0d pixel (%0d,%0d) rgb: got %h expected %h",
                 case_count, x, y, rgb, 12'(exp_rgb));
        bad = 1'b1;
      end
      if (hsync != 1'(exp_h))
      begin
        $display("[FAIL] case %0d pixel (%0d,%0d) hsync: got %h expected %h",
                 case_count, x, y, hsync, 1'(exp_h));
        bad = 1'b1;
      end
      if (vsync != 1'(exp_v))
      begin
        $display("[FAIL] case %0d pixel (%0d,%0d) vsync: got %h expected %h",
                 case_count, x, y, vsync, 1'(exp_v));
        bad = 1'b1;
      end
      if (bad)
        errors++;
      $display("case %0d: probe (%0d,%0d) %s", case_count, x, y, bad ? "failed" : "ok");
    end
  endtask

  task automatic run_cases;
    int    fd;
    string line;
    byte   kind;
    int    rc;
    int    a;
    int    b;
    int    c;
    int    d;
    int    e;
    fd = $fopen("tank_cases.txt", "r");
    if (fd == 0)
    begin
      $display("could not open tank_cases.txt");
      errors++;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        kind = line[0];
        if (kind == "C")
        begin
          case_count++;
          rc = $sscanf(line.substr(1, line.len() - 1), "%d %d", a, b);
          if (rc != 2)
          begin
            $display("case %0d: malformed command line", case_count);
            errors++;
          end
          else
            send_cmd(a, b);
        end
        else if (kind == "P")
        begin
          case_count++;
          rc = $sscanf(line.substr(1, line.len() - 1), "%d %d %h %d %d", a, b, c, d, e);
          if (rc != 5)
          begin
            $display("case %0d: malformed probe line", case_count);
            errors++;
          end
          else
            probe(a, b, c, d, e);
        end
        else if (kind != "#" && kind != "\n" && kind != "\r" && kind != " ")
        begin
          $display("unknown line kind in tank_cases.txt");
          errors++;
        end
      end
      $fclose(fd);
    end
  endtask

  initial
  begin
    bit ok;
    cmd_valid = 1'b0;
    cmd_tank  = 1'b0;
    cmd       = tank_pkg::CMD_NOP;
    wait_reset(ok);
    if (!ok)
    begin
      $display("reset was never released");
      errors++;
    end
    else
      run_cases();
    $display("%0d cases run, %0d errors", case_count, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

//--- tank_cases.txt
# C tank op : tank 1 player 0 enemy, op 1 up 2 down 3 left 4 right 5 spawn 6 kill
# P x y rgb hsync vsync : expected outputs at raster pixel (x,y), rgb in hex
P 200 200 222 1 1
P 100 100 000 1 1
P 600 100 000 1 1
P 700 100 000 0 1
P 100 489 000 1 1
P 100 490 000 1 0
P 100 491 000 1 0
P 100 492 000 1 1
P 300 400 00f 1 1
P 300 60 f00 1 1
P 300 392 00f 1 1
P 300 52 f00 1 1
C 1 4
P 308 400 00f 1 1
P 300 400 00f 1 1
P 300 392 222 1 1
C 1 4
P 320 400 00f 1 1
P 300 400 222 1 1
C 0 1
C 0 1
C 0 1
P 300 40 f00 1 1
P 300 32 f00 1 1
P 300 20 000 1 1
C 0 6
P 300 40 222 1 1
C 0 5
P 300 60 f00 1 1
P 300 52 f00 1 1
P 300 40 222 1 1
C 1 3
C 1 3
C 1 1
C 1 1
C 1 1
C 1 1
C 1 1
C 1 1
C 1 1
C 1 1
C 1 1
C 1 1
C 1 1
C 1 1
C 1 1
C 1 1
C 1 1
C 1 1
C 1 1
C 1 1
P 300 60 00f 1 1
P 300 52 00f 1 1
P 300 400 222 1 1

//--- build.f
tank_pkg.sv
vga_timing.sv
tank_ctrl.sv
tank_render.sv
pixel_mixer.sv
tank_display.sv
tb_clock_gen.sv
tank_display_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tank_display_tb
LINT_TOP  ?= tank_display
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
